// File: include/fp_rename_params.svh
`ifndef FP_RENAME_PARAMS_SVH
`define FP_RENAME_PARAMS_SVH

////////////////////
// Register file sizes
////////////////////

// Architectural FP registers f0..f31
`define FP_NUM_ISA_REGS      32
// Physical FP registers behind the rename map
`define FP_NUM_PHYS_REGS     64
// Free list depth, physical minus architectural
`define FP_NUM_FREE_ENTRIES  32

////////////////////
// Speculation
////////////////////

// One slot is always the live copy, so 3 checkpoints can be in flight
`define FP_NUM_CHECKPOINTS   4

`endif

// File: design/fp_rename_pkg.sv
`include "fp_rename_params.svh"

package fp_rename_pkg;

    // Register and label types
    typedef logic [$clog2(`FP_NUM_ISA_REGS)-1:0]    fareg_t;        // Architectural FP reg
    typedef logic [$clog2(`FP_NUM_PHYS_REGS)-1:0]   phfreg_t;       // Physical FP reg
    typedef logic [$clog2(`FP_NUM_CHECKPOINTS)-1:0] checkpoint_ptr; // Checkpoint slot label

    // One FP instruction offered to rename
    typedef struct packed {
        logic   valid;
        fareg_t rs1;
        fareg_t rs2;
        fareg_t rs3;     // Third source of fused multiply-add
        logic   use_rd;
        fareg_t rd;
    } rename_req_t;

    // Renamed instruction, one cycle after acceptance
    typedef struct packed {
        logic    valid;
        phfreg_t prs1;
        phfreg_t prs2;
        phfreg_t prs3;
        logic    use_rd;
        phfreg_t prd;      // Newly allocated destination
        phfreg_t old_prd;  // Previous mapping of rd, freed at commit
        // Checkpoint label the instruction belongs to
        logic [$clog2(`FP_NUM_CHECKPOINTS)-1:0] checkpoint_ptr;
    } rename_rsp_t;

    // One commit slot
    typedef struct packed {
        logic    valid;
        fareg_t  rd;
        phfreg_t prd;
        phfreg_t old_prd;
    } commit_t;

    // Branch unit controls
    typedef struct packed {
        logic          do_checkpoint;
        logic          do_recover;
        logic          delete_checkpoint;
        checkpoint_ptr recover_checkpoint;
    } branch_ctl_t;

endpackage

// File: design/fp_free_list.sv
`timescale 1ns/1ps
`include "fp_rename_params.svh"

module fp_free_list (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    input  logic                             read_head_i,          // Allocate one register
    input  logic [1:0]                       add_free_register_i,  // Per commit slot
    input  fp_rename_pkg::phfreg_t [1:0]     free_register_i,
    input  logic                             do_checkpoint_i,
    input  logic                             do_recover_i,
    input  logic                             delete_checkpoint_i,  // Oldest branch resolved
    input  fp_rename_pkg::checkpoint_ptr     recover_checkpoint_i,
    input  logic                             commit_roll_back_i,
    output fp_rename_pkg::phfreg_t           new_register_o,
    output fp_rename_pkg::checkpoint_ptr     checkpoint_o,
    output logic                             out_of_checkpoints_o,
    output logic                             empty_o
);

    localparam int NUM_ENTRIES = `FP_NUM_FREE_ENTRIES;
    localparam int NUM_CP      = `FP_NUM_CHECKPOINTS;
    localparam int NUM_ISA     = `FP_NUM_ISA_REGS;
    localparam int PTR_W       = $clog2(NUM_ENTRIES);

    typedef logic [PTR_W-1:0] entry_ptr_t;  // Wraps by itself, depth is a power of two
    typedef logic [PTR_W:0]   entry_cnt_t;  // One bit wider to hold a full count

    // Circular buffer of free registers, shared by all versions
    fp_rename_pkg::phfreg_t register_table [NUM_ENTRIES];

    entry_ptr_t head_q  [NUM_CP];  // Head per checkpoint slot
    entry_cnt_t count_q [NUM_CP];  // Free count per checkpoint slot
    entry_ptr_t tail_q;            // Single tail, frees go to every version

    fp_rename_pkg::checkpoint_ptr version_head_q;  // Live slot
    fp_rename_pkg::checkpoint_ptr version_tail_q;  // Oldest outstanding slot
    fp_rename_pkg::checkpoint_ptr version_next;
    fp_rename_pkg::checkpoint_ptr recover_distance;
    logic [$clog2(NUM_CP):0]      num_checkpoints_q;

    logic       write_en0;
    logic       write_en1;
    logic       read_en;
    logic       checkpoint_en;
    logic       live_empty;
    entry_ptr_t tail_plus_one;
    entry_cnt_t num_written;
    entry_cnt_t live_count_next;
    entry_ptr_t live_head_next;

    ////////////////////
    // Control decode
    ////////////////////

    assign write_en0 = add_free_register_i[0] & ~commit_roll_back_i; // Roll-back drops frees
    assign write_en1 = add_free_register_i[1] & ~commit_roll_back_i;

    assign live_empty = (count_q[version_head_q] == '0);

    // Allocation may be served by a same-cycle free
    assign read_en = read_head_i & (~live_empty | write_en0 | write_en1)
                     & ~do_recover_i & ~commit_roll_back_i;

    assign checkpoint_en = do_checkpoint_i & ~out_of_checkpoints_o
                           & ~do_recover_i & ~commit_roll_back_i;

    assign tail_plus_one    = tail_q + 1'b1;
    assign version_next     = version_head_q + 1'b1;
    assign num_written      = entry_cnt_t'(write_en0) + entry_cnt_t'(write_en1);
    assign live_count_next  = count_q[version_head_q] + num_written - entry_cnt_t'(read_en);
    assign live_head_next   = head_q[version_head_q] + entry_ptr_t'(read_en);
    assign recover_distance = recover_checkpoint_i - version_tail_q; // Modulo slot count

    ////////////////////
    // State update
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version_head_q    <= '0;
            version_tail_q    <= '0;
            num_checkpoints_q <= '0;
            tail_q            <= '0;
            checkpoint_o      <= '0;
            for (int c = 0; c < NUM_CP; c++) begin
                head_q[c]  <= '0;
                count_q[c] <= entry_cnt_t'(NUM_ENTRIES);  // All upper registers free
            end
            for (int j = 0; j < NUM_ENTRIES; j++) begin
                register_table[j] <= fp_rename_pkg::phfreg_t'(NUM_ISA + j); // Entry j = 32+j
            end
        end else if (commit_roll_back_i) begin
            // Everything between head and tail is free again
            version_head_q    <= '0;
            version_tail_q    <= '0;
            num_checkpoints_q <= '0;
            checkpoint_o      <= '0;
            head_q[0]         <= tail_q;
            count_q[0]        <= entry_cnt_t'(NUM_ENTRIES);
        end else begin
            version_tail_q <= version_tail_q + fp_rename_pkg::checkpoint_ptr'(delete_checkpoint_i);
            checkpoint_o   <= version_head_q;  // Label of the slot live this cycle

            // Freed registers, slot 0 first
            if (write_en0) begin
                register_table[tail_q] <= free_register_i[0];
                if (write_en1) register_table[tail_plus_one] <= free_register_i[1];
            end else if (write_en1) begin
                register_table[tail_q] <= free_register_i[1];
            end
            tail_q <= tail_q + entry_ptr_t'(num_written);

            for (int c = 0; c < NUM_CP; c++) begin
                count_q[c] <= count_q[c] + num_written;  // Frees count in every version
            end

            if (do_recover_i) begin
                version_head_q    <= recover_checkpoint_i;           // Back to older slot
                num_checkpoints_q <= {1'b0, recover_distance};
            end else begin
                num_checkpoints_q <= num_checkpoints_q + checkpoint_en - delete_checkpoint_i;
                head_q[version_head_q]  <= live_head_next;
                count_q[version_head_q] <= live_count_next;          // Allocation only live
                if (checkpoint_en) begin
                    // Next slot starts from the state after this cycle
                    version_head_q        <= version_next;
                    head_q[version_next]  <= live_head_next;
                    count_q[version_next] <= live_count_next;
                end
            end
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    always_comb begin
        if (live_empty && write_en0) begin
            new_register_o = free_register_i[0];  // Bypass on empty list
        end else if (live_empty && write_en1) begin
            new_register_o = free_register_i[1];
        end else begin
            new_register_o = register_table[head_q[version_head_q]];
        end
    end

    assign empty_o              = live_empty & ~write_en0 & ~write_en1;
    assign out_of_checkpoints_o = (num_checkpoints_q == (NUM_CP - 1)); // Last slot is live

endmodule

// File: design/fp_rename_table.sv
`timescale 1ns/1ps
`include "fp_rename_params.svh"

module fp_rename_table (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    input  fp_rename_pkg::fareg_t            rs1_i,
    input  fp_rename_pkg::fareg_t            rs2_i,
    input  fp_rename_pkg::fareg_t            rs3_i,
    input  logic                             write_i,       // New mapping for rd
    input  fp_rename_pkg::fareg_t            rd_i,
    input  fp_rename_pkg::phfreg_t           new_prd_i,
    input  fp_rename_pkg::commit_t [1:0]     commit_i,
    input  logic                             do_checkpoint_i,
    input  logic                             do_recover_i,
    input  fp_rename_pkg::checkpoint_ptr     recover_checkpoint_i,
    input  logic                             commit_roll_back_i,
    output fp_rename_pkg::phfreg_t           prs1_o,
    output fp_rename_pkg::phfreg_t           prs2_o,
    output fp_rename_pkg::phfreg_t           prs3_o,
    output fp_rename_pkg::phfreg_t           old_prd_o
);

    localparam int NUM_ISA = `FP_NUM_ISA_REGS;
    localparam int NUM_CP  = `FP_NUM_CHECKPOINTS;

    // One speculative map per checkpoint slot
    fp_rename_pkg::phfreg_t map_q [NUM_CP][NUM_ISA];
    // Map as seen by retired instructions
    fp_rename_pkg::phfreg_t committed_q [NUM_ISA];

    fp_rename_pkg::checkpoint_ptr version_q;     // Live slot, tracks the free list
    fp_rename_pkg::checkpoint_ptr version_next;
    logic                         checkpoint_en;

    // Same qualification as the free list so both stay in step
    assign checkpoint_en = do_checkpoint_i & ~do_recover_i & ~commit_roll_back_i;
    assign version_next  = version_q + 1'b1;

    ////////////////////
    // Lookups
    ////////////////////

    // Sources see the map before this instruction's own rd
    assign prs1_o    = map_q[version_q][rs1_i];
    assign prs2_o    = map_q[version_q][rs2_i];
    assign prs3_o    = map_q[version_q][rs3_i];
    assign old_prd_o = map_q[version_q][rd_i];  // Freed when this instruction commits

    ////////////////////
    // Speculative maps
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version_q <= '0;
            for (int c = 0; c < NUM_CP; c++) begin
                for (int i = 0; i < NUM_ISA; i++) begin
                    map_q[c][i] <= fp_rename_pkg::phfreg_t'(i);  // Identity map
                end
            end
        end else if (commit_roll_back_i) begin
            version_q <= '0;
            for (int c = 0; c < NUM_CP; c++) begin
                for (int i = 0; i < NUM_ISA; i++) begin
                    map_q[c][i] <= committed_q[i];  // Drop all speculative state
                end
            end
        end else if (do_recover_i) begin
            version_q <= recover_checkpoint_i;  // Old slot already holds the snapshot
        end else begin
            if (write_i) map_q[version_q][rd_i] <= new_prd_i;
            if (checkpoint_en) begin
                version_q <= version_next;
                // Copy includes this cycle's write
                for (int i = 0; i < NUM_ISA; i++) begin
                    if (write_i && (rd_i == fp_rename_pkg::fareg_t'(i))) begin
                        map_q[version_next][i] <= new_prd_i;
                    end else begin
                        map_q[version_next][i] <= map_q[version_q][i];
                    end
                end
            end
        end
    end

    ////////////////////
    // Committed map
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_ISA; i++) begin
                committed_q[i] <= fp_rename_pkg::phfreg_t'(i);
            end
        end else if (!commit_roll_back_i) begin
            // Slot 1 is younger, so its write wins on the same rd
            if (commit_i[0].valid) committed_q[commit_i[0].rd] <= commit_i[0].prd;
            if (commit_i[1].valid) committed_q[commit_i[1].rd] <= commit_i[1].prd;
        end
    end

endmodule

// File: design/fp_rename_unit.sv
`timescale 1ns/1ps

module fp_rename_unit (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    input  fp_rename_pkg::rename_req_t       rename_req_i,
    input  fp_rename_pkg::branch_ctl_t       branch_i,
    input  fp_rename_pkg::commit_t [1:0]     commit_i,
    input  logic                             commit_roll_back_i,
    output fp_rename_pkg::rename_rsp_t       rename_rsp_o,
    output fp_rename_pkg::checkpoint_ptr     checkpoint_o,
    output logic                             stall_o
);

    logic                   accept;
    logic                   alloc;         // Accepted and writes rd
    logic                   take_cp;       // Accepted and opens a checkpoint
    logic                   free_empty;
    logic                   out_of_cp;
    fp_rename_pkg::phfreg_t new_prd;
    fp_rename_pkg::phfreg_t prs1, prs2, prs3, old_prd;

    // Response stage registers
    logic                   valid_q;
    logic                   use_rd_q;
    fp_rename_pkg::phfreg_t prs1_q, prs2_q, prs3_q, prd_q, old_prd_q;

    ////////////////////
    // Stall and accept
    ////////////////////

    assign stall_o = rename_req_i.valid & (
                         (rename_req_i.use_rd & free_empty)         // No register to give
                       | (branch_i.do_checkpoint & out_of_cp)       // No slot left
                       | branch_i.do_recover | commit_roll_back_i); // Maps are moving
    assign accept  = rename_req_i.valid & ~stall_o;
    assign alloc   = accept & rename_req_i.use_rd;
    assign take_cp = accept & branch_i.do_checkpoint;

    fp_free_list free_list0 (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .read_head_i          (alloc),
        .add_free_register_i  ({commit_i[1].valid, commit_i[0].valid}),
        .free_register_i      ({commit_i[1].old_prd, commit_i[0].old_prd}),
        .do_checkpoint_i      (take_cp),
        .do_recover_i         (branch_i.do_recover),
        .delete_checkpoint_i  (branch_i.delete_checkpoint),
        .recover_checkpoint_i (branch_i.recover_checkpoint),
        .commit_roll_back_i   (commit_roll_back_i),
        .new_register_o       (new_prd),
        .checkpoint_o         (checkpoint_o),
        .out_of_checkpoints_o (out_of_cp),
        .empty_o              (free_empty)
    );

    fp_rename_table rename_table0 (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .rs1_i                (rename_req_i.rs1),
        .rs2_i                (rename_req_i.rs2),
        .rs3_i                (rename_req_i.rs3),
        .write_i              (alloc),
        .rd_i                 (rename_req_i.rd),
        .new_prd_i            (new_prd),   // Same-cycle allocation
        .commit_i             (commit_i),
        .do_checkpoint_i      (take_cp),
        .do_recover_i         (branch_i.do_recover),
        .recover_checkpoint_i (branch_i.recover_checkpoint),
        .commit_roll_back_i   (commit_roll_back_i),
        .prs1_o               (prs1),
        .prs2_o               (prs2),
        .prs3_o               (prs3),
        .old_prd_o            (old_prd)
    );

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) valid_q <= 1'b0;
        else         valid_q <= accept;
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            prs1_q    <= prs1;
            prs2_q    <= prs2;
            prs3_q    <= prs3;
            use_rd_q  <= rename_req_i.use_rd;
            prd_q     <= rename_req_i.use_rd ? new_prd : '0;
            old_prd_q <= old_prd;
        end
    end

    // Label register in the free list already holds the slot of the last request
    assign rename_rsp_o = '{valid: valid_q, prs1: prs1_q, prs2: prs2_q, prs3: prs3_q,
                            use_rd: use_rd_q, prd: prd_q, old_prd: old_prd_q,
                            checkpoint_ptr: checkpoint_o};

endmodule

// File: dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // 125 MHz
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;  // Released away from the active edge
    end

endmodule

// File: dv/fp_rename_sva.sv
`timescale 1ns/1ps

module fp_rename_sva (
    input logic                         clk_i,
    input logic                         rstn_i,
    input fp_rename_pkg::rename_req_t   req_i,          // Request at the DUT port
    input logic                         stall_i,
    input logic                         free_empty_i,
    input logic                         out_of_cp_i,
    input logic                         roll_back_i,
    input fp_rename_pkg::branch_ctl_t   branch_i,
    input fp_rename_pkg::commit_t [1:0] commit_i,
    input fp_rename_pkg::rename_rsp_t   rsp_i
);

    logic seen_commit_q;  // Set by the first commit after reset

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            seen_commit_q <= 1'b0;
        end else if (commit_i[0].valid || commit_i[1].valid) begin
            seen_commit_q <= 1'b1;
        end
    end

    ////////////////////
    // Properties
    ////////////////////

    // Response is one cycle behind a request taken at the ports
    a_rsp_follows_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
        1'b1 |=> (rsp_i.valid == $past(req_i.valid && !stall_i)))
        else $error("rsp valid does not follow acceptance");

    // An empty-list stall never happens while a commit frees a register
    a_stall_has_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (stall_i && !branch_i.do_recover && !roll_back_i
         && !(branch_i.do_checkpoint && out_of_cp_i))
        |-> (req_i.use_rd && free_empty_i && !commit_i[0].valid && !commit_i[1].valid))
        else $error("stall without a cause");

    // Until a commit only the upper half of the physical file is handed out
    a_prd_upper_half: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rsp_i.valid && rsp_i.use_rd && !seen_commit_q) |-> (rsp_i.prd >= 6'd32))
        else $error("destination below 32 before the first commit");

    // Nothing offered in a recover cycle comes out of the stage
    a_no_accept_in_recover: assert property (@(posedge clk_i) disable iff (!rstn_i)
        branch_i.do_recover |=> !rsp_i.valid)
        else $error("request accepted during recover");

endmodule

bind fp_rename_unit fp_rename_sva sva0 (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_i        (rename_req_i),
    .stall_i      (stall_o),
    .free_empty_i (free_empty),
    .out_of_cp_i  (out_of_cp),
    .roll_back_i  (commit_roll_back_i),
    .branch_i     (branch_i),
    .commit_i     (commit_i),
    .rsp_i        (rename_rsp_o)
);

// File: dv/tb_fp_rename.sv
`timescale 1ns/1ps
`include "fp_rename_params.svh"

module tb_fp_rename;

    localparam int NUM_ISA        = `FP_NUM_ISA_REGS;
    localparam int NUM_FREE       = `FP_NUM_FREE_ENTRIES;
    localparam int NUM_CP         = `FP_NUM_CHECKPOINTS;
    localparam int TIMEOUT_CYCLES = 2000;  // Tests need about 200 cycles

    logic                         clk;
    logic                         rstn;
    fp_rename_pkg::rename_req_t   req;
    fp_rename_pkg::branch_ctl_t   br;
    fp_rename_pkg::commit_t [1:0] cmt;
    logic                         roll_back;
    fp_rename_pkg::rename_rsp_t   rsp;
    fp_rename_pkg::checkpoint_ptr cp_label;
    logic                         stall;

    ////////////////////
    // Reference model
    ////////////////////

    fp_rename_pkg::phfreg_t ref_map [NUM_ISA];        // Live speculative map
    fp_rename_pkg::phfreg_t committed_map [NUM_ISA];
    fp_rename_pkg::phfreg_t free_hist [$];            // Every register ever put on the list
    int                     free_head;                // Next entry to hand out
    fp_rename_pkg::commit_t inflight [$];             // Renamed, not yet committed
    fp_rename_pkg::phfreg_t cp_map [NUM_CP][NUM_ISA]; // Snapshot per label
    int                     cp_head [NUM_CP];
    int                     cp_inflight [NUM_CP];
    int                     live_cp;
    int unsigned            rng_state;
    int                     num_checks;

    tb_clkgen clkgen0 (.clk_o(clk), .rstn_o(rstn));

    fp_rename_unit dut0 (
        .clk_i              (clk),
        .rstn_i             (rstn),
        .rename_req_i       (req),
        .branch_i           (br),
        .commit_i           (cmt),
        .commit_roll_back_i (roll_back),
        .rename_rsp_o       (rsp),
        .checkpoint_o       (cp_label),
        .stall_o            (stall)
    );

    function automatic int unsigned xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int pick_reg();
        return int'(xorshift32() % NUM_ISA);
    endfunction

    function automatic int free_count();
        return free_hist.size() - free_head;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        num_checks++;
        if (got !== expv) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expv);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_rsp(input fp_rename_pkg::rename_rsp_t want);
        check_value("rename_rsp_o.valid", rsp.valid, want.valid);
        check_value("rename_rsp_o.prs1", rsp.prs1, want.prs1);
        check_value("rename_rsp_o.prs2", rsp.prs2, want.prs2);
        check_value("rename_rsp_o.prs3", rsp.prs3, want.prs3);
        check_value("rename_rsp_o.use_rd", rsp.use_rd, want.use_rd);
        check_value("rename_rsp_o.prd", rsp.prd, want.prd);
        check_value("rename_rsp_o.old_prd", rsp.old_prd, want.old_prd);
        check_value("rename_rsp_o.checkpoint_ptr", rsp.checkpoint_ptr, want.checkpoint_ptr);
    endtask

    task automatic clear_inputs();
        req       = '0;
        br        = '0;
        cmt       = '0;
        roll_back = 1'b0;
    endtask

    task automatic init_model();
        free_hist.delete();
        inflight.delete();
        for (int i = 0; i < NUM_ISA; i++) begin
            ref_map[i]       = fp_rename_pkg::phfreg_t'(i);  // Identity after reset
            committed_map[i] = fp_rename_pkg::phfreg_t'(i);
        end
        for (int j = 0; j < NUM_FREE; j++) begin
            free_hist.push_back(fp_rename_pkg::phfreg_t'(NUM_ISA + j));
        end
        free_head = 0;
        live_cp   = 0;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // One accepted request, starts and ends on a falling edge
    task automatic rename_one(input int rs1, input int rs2, input int rs3,
                              input bit use_rd, input int rd, input bit take_cp);
        fp_rename_pkg::rename_rsp_t want;
        fp_rename_pkg::commit_t     entry;
        req.valid        = 1'b1;
        req.rs1          = fp_rename_pkg::fareg_t'(rs1);
        req.rs2          = fp_rename_pkg::fareg_t'(rs2);
        req.rs3          = fp_rename_pkg::fareg_t'(rs3);
        req.use_rd       = use_rd;
        req.rd           = fp_rename_pkg::fareg_t'(rd);
        br.do_checkpoint = take_cp;
        want                = '0;
        want.valid          = 1'b1;
        want.prs1           = ref_map[rs1];  // Sources before own rd
        want.prs2           = ref_map[rs2];
        want.prs3           = ref_map[rs3];
        want.use_rd         = use_rd;
        want.old_prd        = ref_map[rd];
        want.checkpoint_ptr = fp_rename_pkg::checkpoint_ptr'(live_cp);
        if (use_rd) begin
            want.prd      = free_hist[free_head];  // Frees of this cycle already appended
            free_head++;
            ref_map[rd]   = want.prd;
            entry.valid   = 1'b0;
            entry.rd      = fp_rename_pkg::fareg_t'(rd);
            entry.prd     = want.prd;
            entry.old_prd = want.old_prd;
            inflight.push_back(entry);
        end
        if (take_cp) begin
            for (int i = 0; i < NUM_ISA; i++) begin
                cp_map[live_cp][i] = ref_map[i];  // Snapshot includes this rd
            end
            cp_head[live_cp]     = free_head;
            cp_inflight[live_cp] = inflight.size();
            live_cp              = (live_cp + 1) % NUM_CP;
        end
        #1;
        check_value("stall_o", stall, 0);
        @(negedge clk);
        clear_inputs();
        check_rsp(want);
    endtask

    // Held request must not be taken
    task automatic expect_stall();
        #1;
        check_value("stall_o", stall, 1);
        @(negedge clk);
        check_value("rename_rsp_o.valid", rsp.valid, 0);
    endtask

    // Oldest n instructions retire, their old registers go back to the list
    task automatic load_commits(input int n);
        fp_rename_pkg::commit_t c;
        for (int s = 0; s < n; s++) begin
            c                = inflight.pop_front();
            c.valid          = 1'b1;
            cmt[s]           = c;
            free_hist.push_back(c.old_prd);
            committed_map[c.rd] = c.prd;  // Younger slot written last
        end
    endtask

    task automatic commit_cycle(input int n);
        load_commits(n);
        @(negedge clk);
        clear_inputs();
        check_value("rename_rsp_o.valid", rsp.valid, 0);
    endtask

    task automatic recover_to(input int label);
        br.do_recover         = 1'b1;
        br.recover_checkpoint = fp_rename_pkg::checkpoint_ptr'(label);
        req.valid             = 1'b1;  // Offered in the recover cycle
        req.use_rd            = 1'b1;
        req.rd                = 5'd1;
        expect_stall();
        clear_inputs();
        for (int i = 0; i < NUM_ISA; i++) begin
            ref_map[i] = cp_map[label][i];
        end
        free_head = cp_head[label];
        while (inflight.size() > cp_inflight[label]) begin
            void'(inflight.pop_back());  // Squashed after the branch
        end
        live_cp = label;
    endtask

    task automatic roll_back_all();
        roll_back = 1'b1;
        req.valid = 1'b1;
        req.rs1   = 5'd1;
        expect_stall();
        clear_inputs();
        for (int i = 0; i < NUM_ISA; i++) begin
            ref_map[i] = committed_map[i];
        end
        free_head = free_hist.size() - NUM_FREE;  // Last 32 written are free again
        inflight.delete();
        live_cp   = 0;
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic reset_state_test();
        int rd;
        check_value("rename_rsp_o.valid", rsp.valid, 0);
        check_value("stall_o", stall, 0);
        check_value("checkpoint_o", cp_label, 0);
        for (int i = 0; i < NUM_ISA; i += 4) begin
            rename_one(i, i + 1, i + 2, 1'b0, i + 3, 1'b0);  // Identity map
        end
        for (int k = 0; k < 3; k++) begin
            rd = pick_reg();
            rename_one(pick_reg(), pick_reg(), pick_reg(), 1'b1, rd, 1'b0);
            check_value("rename_rsp_o.prd", rsp.prd, NUM_ISA + k);  // 32, 33, 34
        end
    endtask

    task automatic dependency_test();
        int                     rd;
        int                     other;
        fp_rename_pkg::phfreg_t new_prd;
        repeat (8) begin
            rd    = pick_reg();
            other = pick_reg();
            rename_one(other, other, rd, 1'b1, rd, 1'b0);
            new_prd = ref_map[rd];
            rename_one(rd, other, rd, 1'b1, other, 1'b0);  // rs1 and rs3 depend on rd
            check_value("rename_rsp_o.prs1", rsp.prs1, new_prd);
            check_value("rename_rsp_o.prs3", rsp.prs3, new_prd);
        end
    endtask

    task automatic exhaustion_test();
        fp_rename_pkg::phfreg_t freed0;
        fp_rename_pkg::phfreg_t freed1;
        while (free_count() > 0) begin
            rename_one(pick_reg(), pick_reg(), pick_reg(), 1'b1, pick_reg(), 1'b0);
        end
        req.valid  = 1'b1;
        req.use_rd = 1'b1;
        req.rd     = 5'd3;
        expect_stall();
        clear_inputs();
        rename_one(1, 2, 3, 1'b0, 4, 1'b0);  // No rd, so no stall
        freed0 = inflight[0].old_prd;
        freed1 = inflight[1].old_prd;
        commit_cycle(2);
        rename_one(pick_reg(), pick_reg(), pick_reg(), 1'b1, pick_reg(), 1'b0);
        check_value("rename_rsp_o.prd", rsp.prd, freed0);
        rename_one(pick_reg(), pick_reg(), pick_reg(), 1'b1, pick_reg(), 1'b0);
        check_value("rename_rsp_o.prd", rsp.prd, freed1);
        // Empty again, same-cycle free bypasses the buffer
        freed0 = inflight[0].old_prd;
        load_commits(1);
        rename_one(5, 6, 7, 1'b1, 8, 1'b0);
        check_value("rename_rsp_o.prd", rsp.prd, freed0);
    endtask

    task automatic recover_test();
        int                     label;
        int                     rds [5];
        fp_rename_pkg::phfreg_t next_free;
        repeat (8) commit_cycle(2);
        label = live_cp;
        rename_one(1, 2, 3, 1'b0, 0, 1'b1);  // Branch opens a checkpoint
        check_value("checkpoint_o", cp_label, label);
        next_free = free_hist[free_head];
        for (int k = 0; k < 5; k++) begin
            rds[k] = pick_reg();
            rename_one(rds[k], pick_reg(), rds[k], 1'b1, rds[k], 1'b0);
        end
        recover_to(label);
        for (int k = 0; k < 5; k++) begin
            rename_one(rds[k], rds[k], rds[k], 1'b0, 0, 1'b0);  // Map back at checkpoint
        end
        rename_one(0, 0, 0, 1'b1, pick_reg(), 1'b0);
        check_value("rename_rsp_o.prd", rsp.prd, next_free);
    endtask

    task automatic checkpoint_limit_test();
        repeat (NUM_CP - 1) begin
            rename_one(pick_reg(), pick_reg(), pick_reg(), 1'b1, pick_reg(), 1'b1);
        end
        req.valid        = 1'b1;  // Fourth outstanding checkpoint
        req.rs1          = 5'd4;
        br.do_checkpoint = 1'b1;
        expect_stall();
        br.delete_checkpoint = 1'b1;
        expect_stall();            // Count drops only at the edge
        br.delete_checkpoint = 1'b0;
        rename_one(4, 5, 6, 1'b0, 7, 1'b1);
    endtask

    task automatic roll_back_test();
        fp_rename_pkg::phfreg_t first_free;
        br.delete_checkpoint = 1'b1;  // Oldest branch resolves, one slot frees up
        @(negedge clk);
        clear_inputs();
        check_value("rename_rsp_o.valid", rsp.valid, 0);
        rename_one(pick_reg(), pick_reg(), pick_reg(), 1'b1, pick_reg(), 1'b1);
        commit_cycle(2);
        commit_cycle(2);
        check_value("checkpoint_o", cp_label, live_cp);  // Live slot is not 0 here
        roll_back_all();
        check_value("checkpoint_o", cp_label, 0);
        for (int i = 0; i < NUM_ISA; i += 3) begin
            rename_one(i, (i + 1) % NUM_ISA, (i + 2) % NUM_ISA, 1'b0, 0, 1'b0);
        end
        first_free = free_hist[free_head];
        rename_one(1, 2, 3, 1'b1, 9, 1'b0);
        check_value("rename_rsp_o.prd", rsp.prd, first_free);
        repeat (NUM_CP - 1) begin
            rename_one(pick_reg(), pick_reg(), pick_reg(), 1'b0, 0, 1'b1);  // Slots free again
        end
    endtask

    ////////////////////
    // Main and watchdog
    ////////////////////

    initial begin
        clear_inputs();
        init_model();
        rng_state  = 32'd32634;
        num_checks = 0;
        wait (rstn === 1'b1);
        @(negedge clk);
        reset_state_test();
        dependency_test();
        exhaustion_test();
        recover_test();
        checkpoint_limit_test();
        roll_back_test();
        $display("%0d checks done", num_checks);
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: verilog.f
+incdir+include
design/fp_rename_pkg.sv
design/fp_free_list.sv
design/fp_rename_table.sv
design/fp_rename_unit.sv
dv/tb_clkgen.sv
dv/fp_rename_sva.sv
dv/tb_fp_rename.sv

// File: Makefile
# Verilator build and run for the FP rename unit testbench

TOP = tb_fp_rename

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
